/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_lidar_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(BUILD_DIR)

/* project.f */
source/lidar_pkg.sv
source/command_rx.sv
source/tdc_control.sv
source/tdc_spi_master.sv
source/result_fifo.sv
source/serial_tx.sv
source/lidar_top.sv
test/tdc_spi_model.sv
test/tb_lidar_top.sv

/* source/command_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module command_rx (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     serial_in,
  output lidar_pkg::channel_ctrl_t ctrl
);
  import lidar_pkg::*;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_e;

  rx_state_e             state;
  logic [1:0]            rx_sync;
  logic [baud_cnt_w-1:0] baud_cnt;
  logic [2:0]            bit_cnt;
  logic [7:0]            shreg;
  logic                  rx;
  logic                  bit_tick;

  assign rx = rx_sync[1];
  assign bit_tick = (baud_cnt == baud_cnt_w'(baud_div - 1));

  // Line idles high
  always_ff @(posedge clk) begin
    if (reset) begin
      rx_sync <= 2'b11;
    end else begin
      rx_sync <= {rx_sync[0], serial_in};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rx_idle;
      baud_cnt <= '0;
      bit_cnt <= '0;
      ctrl <= '0;
    end else begin
      baud_cnt <= bit_tick ? '0 : baud_cnt + 1'b1;
      case (state)
        rx_idle: begin
          baud_cnt <= '0;
          if (!rx) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          // Half a bit in, a real start bit is still low
          if (baud_cnt == baud_cnt_w'(baud_div / 2 - 1)) begin
            baud_cnt <= '0;
            bit_cnt <= '0;
            state <= rx ? rx_idle : rx_data;
          end
        end
        rx_data: begin
          if (bit_tick) begin
            shreg <= {rx, shreg[7:1]};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= rx_stop;
            end
          end
        end
        rx_stop: begin
          if (bit_tick) begin
            state <= rx_idle;
            // Framing error drops the byte
            if (rx) begin
              case (cmd_opcode_e'(shreg))
                op_enable: ctrl.enable <= 1'b1;
                op_disable: begin
                  ctrl.enable <= 1'b0;
                  ctrl.pause <= 1'b0;
                end
                op_pause: ctrl.pause <= ctrl.enable;
                op_resume: ctrl.pause <= 1'b0;
                default: ctrl <= ctrl;
              endcase
            end
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (reset) ctrl.pause |-> ctrl.enable)
    else $error("command_rx: pause high with channel disabled");

endmodule

`default_nettype wire

/* source/lidar_pkg.sv */
`default_nettype none

package lidar_pkg;

  // Serial command and result lines, clocks per bit
  localparam int baud_div = 8;
  localparam int baud_cnt_w = $clog2(baud_div);

  // TDC SPI clock and reference clock, clocks per half period
  localparam int spi_half_div = 2;
  localparam int spi_cnt_w = $clog2(spi_half_div);
  localparam int ref_half_div = 2;
  localparam int ref_cnt_w = $clog2(ref_half_div);

  // Shot timing
  localparam int shot_period = 1200;
  localparam int shot_cnt_w = $clog2(shot_period);
  localparam int intb_timeout = 200;
  localparam int timeout_cnt_w = $clog2(intb_timeout);

  // Result FIFO depth is 2**fifo_width
  localparam int fifo_width = 4;
  localparam int fifo_depth = 2 ** fifo_width;

  // TDC register read of the measurement result
  localparam logic [7:0] tdc_read_result = 8'h90;

  typedef enum logic [7:0] {
    op_enable  = 8'h01,
    op_disable = 8'h02,
    op_pause   = 8'h03,
    op_resume  = 8'h04
  } cmd_opcode_e;

  typedef enum logic [2:0] {
    idle,
    shoot,
    wait_intb,
    read_cmd,
    read_data,
    push
  } tdc_state_e;

  typedef struct packed {
    logic enable;
    logic pause;
  } channel_ctrl_t;

  // Shot number in the top byte, TDC time below it
  typedef struct packed {
    logic [7:0]  shot_id;
    logic [23:0] tdc_time;
  } tdc_result_t;

  typedef struct packed {
    logic sck;
    logic mosi;
    logic cs_n;
  } spi_pins_t;

endpackage

`default_nettype wire

/* source/lidar_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lidar_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 serial_in,
  input  logic                 tdc_intb,
  input  logic                 tdc_dout,
  output logic                 serial_out,
  output logic                 tdc_enable,
  output logic                 tdc_start_signal,
  output logic                 tdc_ref_clock,
  output lidar_pkg::spi_pins_t tdc_spi
);
  import lidar_pkg::*;

  channel_ctrl_t ctrl;
  tdc_result_t   result;
  tdc_result_t   fifo_head;
  logic          spi_start;
  logic          spi_cs_end;
  logic          spi_busy;
  logic [7:0]    spi_tx_byte;
  logic [7:0]    spi_rx_byte;
  logic          fifo_push;
  logic          fifo_pop;
  logic          fifo_empty;

  assign tdc_enable = ctrl.enable;

  command_rx command_rx (
    .clk(clk),
    .reset(reset),
    .serial_in(serial_in),
    .ctrl(ctrl)
  );

  tdc_control tdc_control (
    .clk(clk),
    .reset(reset),
    .ctrl(ctrl),
    .tdc_intb(tdc_intb),
    .spi_busy(spi_busy),
    .spi_rx_byte(spi_rx_byte),
    .start_signal(tdc_start_signal),
    .ref_clock(tdc_ref_clock),
    .spi_start(spi_start),
    .spi_cs_end(spi_cs_end),
    .spi_tx_byte(spi_tx_byte),
    .push(fifo_push),
    .result(result)
  );

  // Disabling the channel cuts any transfer in progress
  tdc_spi_master tdc_spi_master (
    .clk(clk),
    .reset(reset),
    .start(spi_start),
    .tx_byte(spi_tx_byte),
    .cs_end(spi_cs_end),
    .abort(!ctrl.enable),
    .miso(tdc_dout),
    .busy(spi_busy),
    .rx_byte(spi_rx_byte),
    .pins(tdc_spi)
  );

  result_fifo result_fifo (
    .clk(clk),
    .reset(reset),
    .push(fifo_push),
    .pop(fifo_pop),
    .din(result),
    .dout(fifo_head),
    .empty(fifo_empty),
    .full()
  );

  serial_tx serial_tx (
    .clk(clk),
    .reset(reset),
    .head(fifo_head),
    .empty(fifo_empty),
    .pop(fifo_pop),
    .serial_out(serial_out)
  );

endmodule

`default_nettype wire

/* source/result_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module result_fifo (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   push,
  input  logic                   pop,
  input  lidar_pkg::tdc_result_t din,
  output lidar_pkg::tdc_result_t dout,
  output logic                   empty,
  output logic                   full
);
  import lidar_pkg::*;

  tdc_result_t           mem [fifo_depth];
  logic [fifo_width-1:0] wr_ptr;
  logic [fifo_width-1:0] rd_ptr;
  logic [fifo_width:0]   count;
  logic                  do_push;
  logic                  do_pop;

  // A result arriving at a full FIFO is dropped
  assign do_push = push && !full;
  assign do_pop = pop && !empty;
  assign empty = (count == '0);
  assign full = count[fifo_width];
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
    else $error("result_fifo: pop from empty FIFO");

endmodule

`default_nettype wire

/* source/serial_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module serial_tx (
  input  logic                   clk,
  input  logic                   reset,
  input  lidar_pkg::tdc_result_t head,
  input  logic                   empty,
  output logic                   pop,
  output logic                   serial_out
);
  import lidar_pkg::*;

  typedef enum logic {
    tx_idle,
    tx_send
  } tx_state_e;

  tx_state_e             state;
  logic [baud_cnt_w-1:0] baud_cnt;
  logic [3:0]            bit_cnt;
  logic [1:0]            byte_cnt;
  logic [9:0]            frame;
  logic [23:0]           rest;
  logic                  bit_end;

  assign pop = (state == tx_idle) && !empty;
  assign serial_out = (state == tx_send) ? frame[0] : 1'b1;
  assign bit_end = (baud_cnt == baud_cnt_w'(baud_div - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= tx_idle;
      baud_cnt <= '0;
      bit_cnt <= '0;
      byte_cnt <= '0;
    end else begin
      case (state)
        tx_idle: begin
          if (!empty) begin
            baud_cnt <= '0;
            bit_cnt <= '0;
            byte_cnt <= '0;
            state <= tx_send;
          end
        end
        tx_send: begin
          baud_cnt <= baud_cnt + 1'b1;
          if (bit_end) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
              bit_cnt <= '0;
              byte_cnt <= byte_cnt + 1'b1;
              if (byte_cnt == 2'd3) begin
                state <= tx_idle;
              end
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // Frame is stop, data LSB first, start; shifted out from bit 0
  always_ff @(posedge clk) begin
    if (pop) begin
      frame <= {1'b1, head.shot_id, 1'b0};
      rest <= head.tdc_time;
    end else if (state == tx_send && bit_end) begin
      if (bit_cnt == 4'd9) begin
        // Next byte starts right after the stop bit
        frame <= {1'b1, rest[23:16], 1'b0};
        rest <= {rest[15:0], 8'h00};
      end else begin
        frame <= {1'b1, frame[9:1]};
      end
    end
  end

endmodule

`default_nettype wire

/* source/tdc_control.sv */
`timescale 1ns/1ns
`default_nettype none

module tdc_control (
  input  logic                     clk,
  input  logic                     reset,
  input  lidar_pkg::channel_ctrl_t ctrl,
  input  logic                     tdc_intb,
  input  logic                     spi_busy,
  input  logic [7:0]               spi_rx_byte,
  output logic                     start_signal,
  output logic                     ref_clock,
  output logic                     spi_start,
  output logic                     spi_cs_end,
  output logic [7:0]               spi_tx_byte,
  output logic                     push,
  output lidar_pkg::tdc_result_t   result
);
  import lidar_pkg::*;

  tdc_state_e               state;
  logic [shot_cnt_w-1:0]    shot_cnt;
  logic [timeout_cnt_w-1:0] wait_cnt;
  logic [ref_cnt_w-1:0]     ref_cnt;
  logic [1:0]               intb_sync;
  logic                     busy_q;
  logic                     byte_done;
  logic                     shot_due;
  logic [1:0]               byte_cnt;
  logic [7:0]               shot_id;
  logic [23:0]              time_acc;

  // The master drops busy in the cycle its received byte becomes valid
  assign byte_done = busy_q && !spi_busy;
  assign shot_due = (shot_cnt == shot_cnt_w'(shot_period - 1));
  assign start_signal = (state == shoot);
  assign push = (state == lidar_pkg::push);
  assign result = {shot_id, time_acc};

  // Reference clock runs only while the channel is on
  always_ff @(posedge clk) begin
    if (reset || !ctrl.enable) begin
      ref_cnt <= '0;
      ref_clock <= 1'b0;
    end else if (ref_cnt == ref_cnt_w'(ref_half_div - 1)) begin
      ref_cnt <= '0;
      ref_clock <= !ref_clock;
    end else begin
      ref_cnt <= ref_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      intb_sync <= 2'b11;
      busy_q <= 1'b0;
    end else begin
      intb_sync <= {intb_sync[0], tdc_intb};
      busy_q <= spi_busy;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || !ctrl.enable) begin
      state <= idle;
      shot_cnt <= '0;
      wait_cnt <= '0;
      byte_cnt <= '0;
      shot_id <= '0;
      spi_start <= 1'b0;
      spi_cs_end <= 1'b0;
    end else begin
      spi_start <= 1'b0;
      shot_cnt <= shot_due ? '0 : shot_cnt + 1'b1;
      case (state)
        idle: begin
          // Paused channel lets the timer run but fires nothing
          if (shot_due && !ctrl.pause) begin
            state <= shoot;
          end
        end
        shoot: begin
          wait_cnt <= '0;
          state <= wait_intb;
        end
        wait_intb: begin
          if (!intb_sync[1]) begin
            spi_start <= 1'b1;
            spi_tx_byte <= tdc_read_result;
            spi_cs_end <= 1'b0;
            state <= read_cmd;
          end else if (wait_cnt == timeout_cnt_w'(intb_timeout - 1)) begin
            // Lost shot still takes a number
            shot_id <= shot_id + 1'b1;
            state <= idle;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        read_cmd: begin
          if (byte_done) begin
            spi_start <= 1'b1;
            spi_tx_byte <= 8'h00;
            byte_cnt <= '0;
            state <= read_data;
          end
        end
        read_data: begin
          if (byte_done) begin
            time_acc <= {time_acc[15:0], spi_rx_byte};
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 2'd2) begin
              state <= lidar_pkg::push;
            end else begin
              spi_start <= 1'b1;
              spi_tx_byte <= 8'h00;
              // Third data byte closes the frame
              spi_cs_end <= (byte_cnt == 2'd1);
            end
          end
        end
        lidar_pkg::push: begin
          shot_id <= shot_id + 1'b1;
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (reset) start_signal |=> !start_signal)
    else $error("tdc_control: start pulse longer than one cycle");

  assert property (@(posedge clk) disable iff (reset) spi_start |-> !spi_busy)
    else $error("tdc_control: SPI start while master busy");

endmodule

`default_nettype wire

/* source/tdc_spi_master.sv */
`timescale 1ns/1ns
`default_nettype none

module tdc_spi_master (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic [7:0]           tx_byte,
  input  logic                 cs_end,
  input  logic                 abort,
  input  logic                 miso,
  output logic                 busy,
  output logic [7:0]           rx_byte,
  output lidar_pkg::spi_pins_t pins
);
  import lidar_pkg::*;

  typedef enum logic [1:0] {
    m_idle,
    m_low,
    m_high,
    m_release
  } spi_state_e;

  spi_state_e           state;
  logic [spi_cnt_w-1:0] half_cnt;
  logic [2:0]           bit_cnt;
  logic [6:0]           tx_sh;
  logic                 last_byte;
  logic                 half_done;

  assign half_done = (half_cnt == spi_cnt_w'(spi_half_div - 1));

  always_ff @(posedge clk) begin
    if (reset || abort) begin
      state <= m_idle;
      half_cnt <= '0;
      bit_cnt <= '0;
      busy <= 1'b0;
      pins <= '{sck: 1'b0, mosi: 1'b0, cs_n: 1'b1};
    end else begin
      half_cnt <= half_done ? '0 : half_cnt + 1'b1;
      case (state)
        m_idle: begin
          half_cnt <= '0;
          if (start) begin
            // MSB goes out with the chip select, ahead of the first rise
            tx_sh <= tx_byte[6:0];
            last_byte <= cs_end;
            bit_cnt <= '0;
            busy <= 1'b1;
            pins.cs_n <= 1'b0;
            pins.mosi <= tx_byte[7];
            state <= m_low;
          end
        end
        m_low: begin
          if (half_done) begin
            pins.sck <= 1'b1;
            rx_byte <= {rx_byte[6:0], miso};
            state <= m_high;
          end
        end
        m_high: begin
          if (half_done) begin
            pins.sck <= 1'b0;
            if (bit_cnt == 3'd7) begin
              busy <= 1'b0;
              state <= last_byte ? m_release : m_idle;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              pins.mosi <= tx_sh[6];
              tx_sh <= {tx_sh[5:0], 1'b0};
              state <= m_low;
            end
          end
        end
        m_release: begin
          // Chip select rises one half period after the last fall
          if (half_done) begin
            pins.cs_n <= 1'b1;
            pins.mosi <= 1'b0;
            state <= m_idle;
          end
        end
        default: state <= m_idle;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (reset) pins.cs_n |-> !pins.sck)
    else $error("tdc_spi_master: sck active with cs_n high");

endmodule

`default_nettype wire

/* test/tb_lidar_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_lidar_top;
  import lidar_pkg::*;

  logic        clk = 1'b0;
  logic        reset;
  logic        serial_in;
  logic        tdc_intb;
  logic        tdc_dout;
  logic        serial_out;
  logic        tdc_enable;
  logic        tdc_start_signal;
  logic        tdc_ref_clock;
  spi_pins_t   tdc_spi;
  logic        skip_intb;
  logic        frame_end;
  logic        served;
  logic [7:0]  frame_bits;
  logic [7:0]  cmd_byte;
  tdc_result_t served_word;
  tdc_result_t expected_q[$];
  tdc_result_t got_q[$];
  tdc_result_t rx_word;
  int          rx_bytes = 0;
  int          pulse_cnt = 0;
  int          mismatch_cnt = 0;
  int          fail_cnt = 0;
  int          ref_held = 0;
  logic        ref_prev = 1'b0;
  string       test_name = "reset";

  lidar_top dut (
    .clk(clk),
    .reset(reset),
    .serial_in(serial_in),
    .tdc_intb(tdc_intb),
    .tdc_dout(tdc_dout),
    .serial_out(serial_out),
    .tdc_enable(tdc_enable),
    .tdc_start_signal(tdc_start_signal),
    .tdc_ref_clock(tdc_ref_clock),
    .tdc_spi(tdc_spi)
  );

  tdc_spi_model model (
    .clk(clk),
    .enable(tdc_enable),
    .start_signal(tdc_start_signal),
    .skip(skip_intb),
    .spi(tdc_spi),
    .intb(tdc_intb),
    .dout(tdc_dout),
    .frame_end(frame_end),
    .frame_bits(frame_bits),
    .cmd_byte(cmd_byte),
    .served(served),
    .served_word(served_word)
  );

  always #2 clk = ~clk;

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    mismatch_cnt++;
    $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
  endtask

  task automatic report_failure(input string msg);
    fail_cnt++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  task automatic print_summary();
    $display("Error count: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
  endtask

  task automatic abort_run(input string msg);
    report_failure(msg);
    print_summary();
    $display("Some tests failed");
    $finish;
  endtask

  assert property (@(posedge clk) disable iff (reset) tdc_start_signal |=> !tdc_start_signal)
    else report_failure("start pulse longer than one cycle");

  assert property (@(posedge clk) disable iff (reset) tdc_spi.cs_n |-> !tdc_spi.sck)
    else report_failure("sck active while cs_n is high");

  assert property (@(posedge clk) disable iff (reset) frame_end |-> frame_bits == 8'd32)
    else report_mismatch("sck edges per cs_n frame", 32'd32, 32'(frame_bits));

  assert property (@(posedge clk) disable iff (reset) frame_end |-> cmd_byte == tdc_read_result)
    else report_mismatch("first mosi byte", 32'(tdc_read_result), 32'(cmd_byte));

  assert property (@(posedge clk) disable iff (reset) !tdc_enable |=> !tdc_ref_clock)
    else report_failure("reference clock runs while disabled");

  // Cycles the reference clock has held its current level while enabled
  always @(posedge clk) begin
    if (!tdc_enable) begin
      ref_held <= 0;
    end else if (tdc_ref_clock == ref_prev) begin
      ref_held <= ref_held + 1;
    end else begin
      ref_held <= 1;
    end
    ref_prev <= tdc_ref_clock;
  end

  assert property (@(posedge clk) disable iff (reset)
                   tdc_enable && $changed(tdc_ref_clock) |-> ref_held == ref_half_div)
    else report_mismatch("reference clock half period", 32'(ref_half_div),
                         32'($sampled(ref_held)));

  assert property (@(posedge clk) disable iff (reset) ref_held <= ref_half_div)
    else report_failure("reference clock stopped toggling while enabled");

  // Start pulses counted and served shots queued as the model reports them
  always @(posedge clk) begin
    if (tdc_start_signal) begin
      pulse_cnt++;
    end
    if (served) begin
      expected_q.push_back(served_word);
    end
  end

  // 8N1 decoder sampling each bit at mid bit and packing four bytes per word
  always begin : serial_decode
    logic [7:0] rx_byte;
    @(posedge clk);
    if (!reset && !serial_out) begin
      repeat (baud_div / 2 - 1) @(posedge clk);
      if (!serial_out) begin
        for (int i = 0; i < 8; i++) begin
          repeat (baud_div) @(posedge clk);
          rx_byte = {serial_out, rx_byte[7:1]};
        end
        repeat (baud_div) @(posedge clk);
        assert (serial_out) else report_failure("stop bit low on serial_out");
        rx_word = {rx_word[23:0], rx_byte};
        rx_bytes++;
        if (rx_bytes == 4) begin
          got_q.push_back(rx_word);
          rx_bytes = 0;
        end
      end
    end
  end

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic send_command(input logic [7:0] value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    for (int i = 0; i < 10; i++) begin
      serial_in = frame[i];
      repeat (baud_div) tick();
    end
    repeat (2 * baud_div) tick();
  endtask

  task automatic next_word(input logic [7:0] exp_id);
    tdc_result_t got;
    tdc_result_t exp;
    int          waited;
    waited = 0;
    while (got_q.size() == 0 && waited < 3 * shot_period) begin
      tick();
      waited++;
    end
    if (got_q.size() == 0) begin
      abort_run("timed out waiting for a result word on serial_out");
    end else begin
      got = got_q.pop_front();
      if (expected_q.size() == 0) begin
        report_failure("result word arrived with no shot served by the TDC model");
      end else begin
        exp = expected_q.pop_front();
        assert (got == exp) else report_mismatch("result word", exp, got);
      end
      assert (got.shot_id == exp_id)
        else report_mismatch("shot_id", 32'(exp_id), 32'(got.shot_id));
    end
  endtask

  task automatic wait_pulse();
    int mark;
    int waited;
    mark = pulse_cnt;
    waited = 0;
    while (pulse_cnt == mark && waited < 2 * shot_period) begin
      tick();
      waited++;
    end
    if (pulse_cnt == mark) begin
      abort_run("timed out waiting for a start pulse");
    end
  endtask

  task automatic check_idle(input int cycles);
    int mark;
    mark = pulse_cnt;
    for (int i = 0; i < cycles; i++) begin
      tick();
      assert (!tdc_enable && tdc_spi.cs_n && !tdc_spi.sck && !tdc_spi.mosi
              && serial_out && !tdc_ref_clock)
        else report_failure("channel outputs not idle while disabled");
    end
    assert (pulse_cnt == mark)
      else report_mismatch("start pulses while disabled", 32'd0, 32'(pulse_cnt - mark));
  endtask

  task automatic check_no_pulses(input int cycles, input int mark);
    for (int i = 0; i < cycles; i++) begin
      tick();
      assert (tdc_enable) else report_failure("tdc_enable dropped while paused");
    end
    assert (pulse_cnt == mark)
      else report_mismatch("start pulses while paused", 32'd0, 32'(pulse_cnt - mark));
  endtask

  initial begin
    int mark;
    reset = 1'b1;
    serial_in = 1'b1;
    skip_intb = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    test_name = "idle after reset";
    check_idle(shot_period + 100);

    test_name = "enable";
    send_command(op_enable);
    assert (tdc_enable) else report_failure("tdc_enable did not rise after op_enable");
    for (int id = 0; id < 3; id++) begin
      next_word(8'(id));
    end

    test_name = "spi framing";
    next_word(8'd3);

    // Shot 4 gets no interrupt and must time out
    test_name = "interrupt timeout";
    skip_intb = 1'b1;
    wait_pulse();
    skip_intb = 1'b0;
    next_word(8'd5);

    test_name = "pause";
    mark = pulse_cnt;
    send_command(op_pause);
    check_no_pulses(shot_period * 3 / 2, mark);

    test_name = "non-opcode bytes";
    mark = pulse_cnt;
    send_command(8'h55);
    send_command(8'hff);
    send_command(8'h00);
    check_no_pulses(shot_period, mark);

    test_name = "pause during a shot";
    send_command(op_resume);
    wait_pulse();
    send_command(op_pause);
    next_word(8'd6);
    mark = pulse_cnt;
    check_no_pulses(shot_period * 3 / 2, mark);

    test_name = "resume";
    send_command(op_resume);
    next_word(8'd7);

    test_name = "disable";
    send_command(op_disable);
    check_idle(shot_period * 3 / 2);

    test_name = "enable again";
    send_command(op_enable);
    next_word(8'd0);
    next_word(8'd1);
    send_command(op_disable);
    repeat (10) tick();
    assert (got_q.size() == 0 && expected_q.size() == 0)
      else report_failure("result words left over at the end of the run");

    print_summary();
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/tdc_spi_model.sv */
`timescale 1ns/1ns
`default_nettype none

module tdc_spi_model (
  input  logic                   clk,
  input  logic                   enable,
  input  logic                   start_signal,
  input  logic                   skip,
  input  lidar_pkg::spi_pins_t   spi,
  output logic                   intb,
  output logic                   dout,
  output logic                   frame_end,
  output logic [7:0]             frame_bits,
  output logic [7:0]             cmd_byte,
  output logic                   served,
  output lidar_pkg::tdc_result_t served_word
);
  import lidar_pkg::*;

  logic [15:0] lfsr;
  logic [7:0]  shot_cnt;
  logic [7:0]  cur_id;
  logic [23:0] cur_time;
  logic [23:0] time_sh;
  spi_pins_t   pins_q;
  int          bit_idx;
  int          intb_delay;

  // Fibonacci taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  initial begin : model_proc
    spi_pins_t pins_s;
    logic      start_s;
    logic      skip_s;
    logic      en_s;
    lfsr = 16'd93;
    shot_cnt = '0;
    cur_id = '0;
    cur_time = '0;
    time_sh = '0;
    pins_q = '{sck: 1'b0, mosi: 1'b0, cs_n: 1'b1};
    bit_idx = 0;
    intb_delay = -1;
    intb = 1'b1;
    dout = 1'b0;
    frame_end = 1'b0;
    frame_bits = '0;
    cmd_byte = '0;
    served = 1'b0;
    served_word = '0;
    forever begin
      @(posedge clk);
      pins_s = spi;
      start_s = start_signal;
      skip_s = skip;
      en_s = enable;
      #1;
      frame_end = 1'b0;
      served = 1'b0;
      if (!en_s) begin
        shot_cnt = '0;
        intb = 1'b1;
        dout = 1'b0;
        intb_delay = -1;
      end else begin
        if (start_s) begin
          cur_id = shot_cnt;
          shot_cnt = shot_cnt + 8'd1;
          // Skipped shot never pulls the interrupt
          intb_delay = skip_s ? -1 : 3;
        end else if (intb_delay == 0) begin
          intb = 1'b0;
          intb_delay = -1;
        end else if (intb_delay > 0) begin
          intb_delay = intb_delay - 1;
        end
        if (pins_q.cs_n && !pins_s.cs_n) begin
          bit_idx = 0;
          cmd_byte = '0;
          for (int i = 0; i < 24; i++) begin
            lfsr = lfsr_step(lfsr);
            cur_time = {cur_time[22:0], lfsr[0]};
          end
          time_sh = cur_time;
        end
        if (!pins_q.sck && pins_s.sck) begin
          if (bit_idx < 8) begin
            cmd_byte = {cmd_byte[6:0], pins_s.mosi};
          end
          bit_idx++;
        end
        // Time bits leave MSB first after each falling sck
        if (pins_q.sck && !pins_s.sck && bit_idx >= 8 && bit_idx < 32) begin
          dout = time_sh[23];
          time_sh = {time_sh[22:0], 1'b0};
        end
        if (!pins_q.cs_n && pins_s.cs_n) begin
          intb = 1'b1;
          dout = 1'b0;
          frame_end = 1'b1;
          frame_bits = 8'(bit_idx);
          if (bit_idx == 32) begin
            served = 1'b1;
            served_word = {cur_id, cur_time};
          end
        end
      end
      pins_q = pins_s;
    end
  end

endmodule

`default_nettype wire
